// ==== testbench/program_input.txt ====
// word image: program at 0x000, data at 0x100, events from word 0x80
// event = kind (1 wb, 2 store, 3 csr), field a, field b, size
@00
00500093 00700013 12345137 67810113 10000193 0001A203 00018283 00219303
0011C383 0041D403 00140493 0021A423 00919623 00518823 0081A503 34011073
@40
A5B6C7D8 11223344
@80
00000001 00000001 00000005 00000000  00000001 00000002 12345000 00000000
00000001 00000002 12345678 00000000  00000001 00000003 00000100 00000000
00000001 00000004 A5B6C7D8 00000000  00000001 00000005 FFFFFFD8 00000000
00000001 00000006 FFFFA5B6 00000000  00000001 00000007 000000C7 00000000
00000001 00000008 00003344 00000000  00000001 00000009 00003345 00000000
00000002 00000108 12345678 00000002  00000002 0000010C 00003345 00000001
00000002 00000110 FFFFFFD8 00000000  00000001 0000000A 12345678 00000000
00000003 00000340 12345678 00000000  00000000

// ==== sim.f ====
verilog/core_pkg.sv
verilog/bus_pkg.sv
verilog/fetch_unit.sv
verilog/insn_decode.sv
verilog/exec_unit.sv
verilog/mem_arbiter.sv
verilog/core_top.sv
testbench/core_chk.sv
testbench/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module core_tb -f sim.f -o core_sim
./obj_dir/core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx ">>> PASS" sim.log; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

// ==== testbench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb import core_pkg::*, bus_pkg::*; ();

    logic        clock = 1'b0;
    logic        reset;
    logic        rd_valid;
    mem_rd_req_t rd_req;
    logic        rd_ready;
    logic [31:0] rd_data;
    logic        wr_valid;
    mem_wr_req_t wr_req;
    logic        wr_ready;
    logic        wb_valid;
    wb_t         wb;
    logic        csr_valid;
    csr_ev_t     csr_ev;

    // memory in words 0..127 and expected events from word 128
    logic [31:0] image [0:255];

    wb_t         exp_wb[$];
    mem_wr_req_t exp_wr[$];
    csr_ev_t     exp_csr[$];

    int          seed = 32'hd77163d2;
    int          reset_count = 0;
    logic [1:0]  rd_wait = 2'd0;
    logic [1:0]  wr_wait = 2'd0;
    logic        seen_fetch = 1'b0;

    core_top u_core_top (.*);

    initial begin
        forever #5 clock = ~clock;
    end

    task automatic abort_run(input string line);
        $display(">>> FAIL");
        $display("%s", line);
        $fatal(1);
    endtask

    // ------------------------------
    // memory model helpers
    // ------------------------------
    function automatic logic [31:0] read_value(input mem_rd_req_t req);
        logic [31:0] word;
        logic [31:0] shifted;
        word    = (req.addr < 32'h200) ? image[req.addr[8:2]] : 32'd0;
        shifted = word >> {req.addr[1:0], 3'b000};
        case (req.size)
            SIZE_BYTE: return req.sign_ext ? {{24{shifted[7]}}, shifted[7:0]}
                                           : {24'd0, shifted[7:0]};
            SIZE_HALF: return req.sign_ext ? {{16{shifted[15]}}, shifted[15:0]}
                                           : {16'd0, shifted[15:0]};
            default:   return word;
        endcase
    endfunction

    task automatic write_mem(input mem_wr_req_t req);
        logic [31:0] word;
        if (req.addr < 32'h200) begin
            word = image[req.addr[8:2]];
            case (req.size)
                SIZE_BYTE: word[{req.addr[1:0], 3'b000} +: 8] = req.data[7:0];
                SIZE_HALF: word[{req.addr[1], 4'b0000} +: 16] = req.data[15:0];
                default:   word = req.data;
            endcase
            image[req.addr[8:2]] = word;
        end
    endtask

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_wb(input wb_t got);
        wb_t exp;
        if (exp_wb.size() == 0) begin
            abort_run($sformatf("unexpected writeback of %h to x%0d at %0t",
                                got.data, got.rd, $time));
        end else begin
            exp = exp_wb.pop_front();
            if (got !== exp)
                abort_run($sformatf("mismatch at %0t: writeback x%0d=%h, expected x%0d=%h",
                                    $time, got.rd, got.data, exp.rd, exp.data));
        end
    endtask

    task automatic check_wr(input mem_wr_req_t got);
        mem_wr_req_t exp;
        if (exp_wr.size() == 0) begin
            abort_run($sformatf("unexpected store to %h at %0t", got.addr, $time));
        end else begin
            exp = exp_wr.pop_front();
            if (got !== exp)
                abort_run($sformatf(
                    "mismatch at %0t: store %h<=%h size %0d, expected %h<=%h size %0d",
                    $time, got.addr, got.data, got.size, exp.addr, exp.data, exp.size));
        end
    endtask

    task automatic check_csr(input csr_ev_t got);
        csr_ev_t exp;
        if (exp_csr.size() == 0) begin
            abort_run($sformatf("unexpected CSR write to %h at %0t", got.addr, $time));
        end else begin
            exp = exp_csr.pop_front();
            if (got !== exp)
                abort_run($sformatf("mismatch at %0t: csr %h<=%h, expected %h<=%h",
                                    $time, got.addr, got.data, exp.addr, exp.data));
        end
    endtask

    // ------------------------------
    // reset, memory responses, monitors
    // ------------------------------
    always @(negedge clock) begin
        if (reset_count < 3) begin
            reset_count = reset_count + 1;
            if (reset_count == 3)
                reset = 1'b0;
        end
        if (reset) begin
            rd_ready = 1'b0;
            wr_ready = 1'b0;
        end else begin
            if (rd_valid && rd_wait == 2'd0) begin
                rd_ready = 1'b1;
                rd_data  = read_value(rd_req);
            end else begin
                rd_ready = 1'b0;
                if (rd_valid)
                    rd_wait = rd_wait - 2'd1;
            end
            if (wr_valid && wr_wait == 2'd0) begin
                wr_ready = 1'b1;
            end else begin
                wr_ready = 1'b0;
                if (wr_valid)
                    wr_wait = wr_wait - 2'd1;
            end

            // sample just before the rising edge
            #4;
            if (!seen_fetch && (wb_valid || csr_valid || wr_valid))
                abort_run("a result appeared before the first fetch request");
            if (!seen_fetch && rd_valid) begin
                seen_fetch = 1'b1;
                if (rd_req.addr !== 32'd0)
                    abort_run($sformatf("mismatch at %0t: first fetch at %h, expected 0",
                                        $time, rd_req.addr));
            end
            if (rd_valid && rd_ready)
                rd_wait = 2'($unsigned($random(seed)));
            if (wr_valid && wr_ready) begin
                check_wr(wr_req);
                write_mem(wr_req);
                wr_wait = 2'($unsigned($random(seed)));
            end
            if (wb_valid)
                check_wb(wb);
            if (csr_valid)
                check_csr(csr_ev);
        end
    end

    initial begin
        int          idx;
        int          cycles;
        wb_t         e_wb;
        mem_wr_req_t e_wr;
        csr_ev_t     e_csr;

        reset    = 1'b1;
        rd_ready = 1'b0;
        rd_data  = 32'd0;
        wr_ready = 1'b0;
        // opcode field left zero so unloaded words decode as no-ops
        for (idx = 0; idx < 256; idx++)
            image[idx] = {idx[7:0], 24'd0};
        $readmemh("testbench/program_input.txt", image);

        // each event is four words of kind and three fields
        idx = 128;
        while (idx < 252 && image[idx] >= 32'd1 && image[idx] <= 32'd3) begin
            case (image[idx])
                32'd1: begin
                    e_wb.rd   = image[idx + 1][4:0];
                    e_wb.data = image[idx + 2];
                    exp_wb.push_back(e_wb);
                end
                32'd2: begin
                    e_wr.addr = image[idx + 1];
                    e_wr.data = image[idx + 2];
                    e_wr.size = mem_size_e'(image[idx + 3][1:0]);
                    exp_wr.push_back(e_wr);
                end
                default: begin
                    e_csr.addr = image[idx + 1][11:0];
                    e_csr.data = image[idx + 2];
                    exp_csr.push_back(e_csr);
                end
            endcase
            idx = idx + 4;
        end

        cycles = 0;
        while (exp_wb.size() != 0 || exp_wr.size() != 0 || exp_csr.size() != 0) begin
            @(posedge clock);
            cycles = cycles + 1;
            if (cycles > 3000)
                abort_run("timeout: not all expected events were seen within 3000 cycles");
        end
        // let a stray x0 writeback or extra event show up
        repeat (5) @(posedge clock);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== testbench/core_chk.sv ====
`timescale 1ns/1ps

module core_chk import core_pkg::*, bus_pkg::*; (
    input logic        clock,
    input logic        reset,
    input logic        rd_valid,
    input mem_rd_req_t rd_req,
    input logic        rd_ready,
    input logic        wr_valid,
    input mem_wr_req_t wr_req,
    input logic        wr_ready,
    input logic        op_valid,
    input logic        op_ready,
    input exec_op_t    op,
    input logic        busy
);

    // only one of read and write requested at a time
    one_request_at_a_time: assert property (@(posedge clock) disable iff (reset)
        !(rd_valid && wr_valid))
        else $error("read and write requests raised together");

    read_request_held: assert property (@(posedge clock) disable iff (reset)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_req))
        else $error("read request dropped or changed before its handshake");

    write_request_held: assert property (@(posedge clock) disable iff (reset)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_req))
        else $error("write request dropped or changed before its handshake");

    // an accepted load or store keeps further ops out until its handshake
    no_accept_while_busy: assert property (@(posedge clock) disable iff (reset)
        (op_valid && op_ready && (op.kind == OP_LOAD || op.kind == OP_STORE)) ||
        (busy && !(rd_valid && rd_ready) && !(wr_valid && wr_ready))
        |=> busy && !op_ready)
        else $error("data access ended early or op_ready rose while busy");

endmodule

bind mem_arbiter core_chk u_chk (.*);

// ==== verilog/core_top.sv ====
`timescale 1ns/1ps

module core_top import core_pkg::*, bus_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    output logic        rd_valid,
    output mem_rd_req_t rd_req,
    input  logic        rd_ready,
    input  logic [31:0] rd_data,

    output logic        wr_valid,
    output mem_wr_req_t wr_req,
    input  logic        wr_ready,

    output logic        wb_valid,
    output wb_t         wb,
    output logic        csr_valid,
    output csr_ev_t     csr_ev
);

    // fetch to decode
    logic        insn_valid;
    logic        insn_ready;
    insn_u       insn_word;

    // fetch to arbiter
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    logic        fetch_ready;
    logic [31:0] fetch_data;

    // decode to execute
    logic        dec_valid;
    logic        dec_ready;
    decoded_op_t dec_op;

    // execute to arbiter
    logic        op_valid;
    logic        op_ready;
    exec_op_t    op;

    fetch_unit u_fetch (
        .clock       (clock),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .insn_valid  (insn_valid),
        .insn_ready  (insn_ready),
        .insn_word   (insn_word)
    );

    insn_decode u_decode (
        .clock      (clock),
        .reset      (reset),
        .insn_valid (insn_valid),
        .insn_ready (insn_ready),
        .insn_word  (insn_word),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .dec_op     (dec_op)
    );

    // writeback feeds the register file and leaves the core
    exec_unit u_exec (
        .clock     (clock),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_op    (dec_op),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op        (op),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

    mem_arbiter u_arbiter (
        .clock       (clock),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .op_valid    (op_valid),
        .op_ready    (op_ready),
        .op          (op),
        .rd_valid    (rd_valid),
        .rd_req      (rd_req),
        .rd_ready    (rd_ready),
        .rd_data     (rd_data),
        .wr_valid    (wr_valid),
        .wr_req      (wr_req),
        .wr_ready    (wr_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .csr_valid   (csr_valid),
        .csr_ev      (csr_ev)
    );

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter import core_pkg::*, bus_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    input  logic        fetch_valid,
    input  logic [31:0] fetch_addr,
    output logic        fetch_ready,
    output logic [31:0] fetch_data,

    input  logic        op_valid,
    output logic        op_ready,
    input  exec_op_t    op,

    output logic        rd_valid,
    output mem_rd_req_t rd_req,
    input  logic        rd_ready,
    input  logic [31:0] rd_data,

    output logic        wr_valid,
    output mem_wr_req_t wr_req,
    input  logic        wr_ready,

    output logic        wb_valid,
    output wb_t         wb,
    output logic        csr_valid,
    output csr_ev_t     csr_ev
);

    logic        load_pend;
    logic        store_pend;
    logic        busy;
    mem_rd_req_t load_req;
    mem_wr_req_t store_req;
    logic [4:0]  load_rd;

    logic        fetch_sel;
    logic        op_is_mem;
    logic        op_acc;
    logic        load_done;
    logic        store_done;

    // ------------------------------
    // port selection
    // ------------------------------
    assign busy      = load_pend | store_pend;
    assign fetch_sel = !busy && fetch_valid;
    assign op_is_mem = (op.kind == OP_LOAD) || (op.kind == OP_STORE);

    // a pending fetch keeps memory ops out so the port never changes hands mid-request
    assign op_ready  = !busy && !(fetch_valid && op_is_mem);
    assign op_acc    = op_valid && op_ready;

    always_comb begin
        if (fetch_sel) begin
            rd_valid        = 1'b1;
            rd_req.addr     = fetch_addr;
            rd_req.size     = SIZE_WORD;
            rd_req.sign_ext = 1'b0;
        end else begin
            rd_valid = load_pend;
            rd_req   = load_req;
        end
    end

    assign fetch_ready = fetch_sel && rd_ready;
    assign fetch_data  = rd_data;

    assign wr_valid = store_pend;
    assign wr_req   = store_req;

    assign load_done  = load_pend && rd_ready;
    assign store_done = store_pend && wr_ready;

    // ------------------------------
    // results
    // ------------------------------
    // load completion and a new alu op never share a cycle, busy blocks the op
    assign wb_valid = load_done ||
                      (op_acc && op.kind == OP_ALU && op.rd != 5'd0);
    assign wb.rd    = load_pend ? load_rd : op.rd;
    assign wb.data  = load_pend ? rd_data : op.alu;

    assign csr_valid   = op_acc && op.kind == OP_CSR_WRITE;
    assign csr_ev.addr = op.csr_addr;
    assign csr_ev.data = op.csr_data;

    // ------------------------------
    // outstanding data access
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            load_pend  <= 1'b0;
            store_pend <= 1'b0;
        end else begin
            if (op_acc && op.kind == OP_LOAD)
                load_pend <= 1'b1;
            else if (load_done)
                load_pend <= 1'b0;

            if (op_acc && op.kind == OP_STORE)
                store_pend <= 1'b1;
            else if (store_done)
                store_pend <= 1'b0;
        end
    end

    // request fields captured at acceptance, held until the handshake
    always_ff @(posedge clock) begin
        if (op_acc && op.kind == OP_LOAD) begin
            load_req.addr     <= op.addr;
            load_req.size     <= op.size;
            load_req.sign_ext <= op.sign_ext;
            load_rd           <= op.rd;
        end
        if (op_acc && op.kind == OP_STORE) begin
            store_req.addr <= op.addr;
            store_req.data <= op.wdata;
            store_req.size <= op.size;
        end
    end

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import core_pkg::*, bus_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    input  logic        dec_valid,
    output logic        dec_ready,
    input  decoded_op_t dec_op,

    output logic        op_valid,
    input  logic        op_ready,
    output exec_op_t    op,

    input  logic        wb_valid,
    input  wb_t         wb
);

    // x0 has no storage
    logic [31:0] regs [1:31];
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] sum;

    // ------------------------------
    // register file
    // ------------------------------
    always_ff @(posedge clock) begin
        if (!reset && wb_valid && wb.rd != 5'd0)
            regs[wb.rd] <= wb.data;
    end

    assign rs1_val = (dec_op.rs1 == 5'd0) ? 32'd0 : regs[dec_op.rs1];
    assign rs2_val = (dec_op.rs2 == 5'd0) ? 32'd0 : regs[dec_op.rs2];

    // ------------------------------
    // operand and result
    // ------------------------------
    // addi result and load/store address share one adder
    assign sum = rs1_val + dec_op.imm;

    always_comb begin
        op          = '0;
        op.kind     = dec_op.kind;
        op.rd       = dec_op.rd;
        op.addr     = sum;
        op.wdata    = rs2_val;
        op.alu      = dec_op.lui ? dec_op.imm : sum;
        op.size     = dec_op.size;
        op.sign_ext = dec_op.sign_ext;
        op.csr_addr = dec_op.csr_addr;
        op.csr_data = rs1_val;
    end

    // no stage of its own, handshake passes straight through
    assign op_valid  = dec_valid;
    assign dec_ready = op_ready;

endmodule

// ==== verilog/insn_decode.sv ====
`timescale 1ns/1ps

module insn_decode import core_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    input  logic        insn_valid,
    output logic        insn_ready,
    input  insn_u       insn_word,

    output logic        dec_valid,
    input  logic        dec_ready,
    output decoded_op_t dec_op
);

    decoded_op_t dec_next;
    logic        slot_valid;
    decoded_op_t slot_op;

    function automatic mem_size_e size_of(input logic [2:0] funct3);
        case (funct3[1:0])
            2'b00:   return SIZE_BYTE;
            2'b01:   return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    // ------------------------------
    // field extraction
    // ------------------------------
    always_comb begin
        dec_next          = '0;
        dec_next.kind     = OP_ALU;
        dec_next.size     = SIZE_WORD;
        dec_next.rd       = insn_word.i_form.rd;
        dec_next.rs1      = insn_word.i_form.rs1;
        dec_next.rs2      = insn_word.s_form.rs2;
        dec_next.imm      = {{20{insn_word.i_form.imm12[11]}}, insn_word.i_form.imm12};
        dec_next.csr_addr = insn_word.i_form.imm12;

        case (insn_word.i_form.opcode)
            OPC_OP_IMM: begin
                // only addi, other funct3 retire as a no-op
                if (insn_word.i_form.funct3 != 3'b000)
                    dec_next.rd = 5'd0;
            end
            OPC_LUI: begin
                dec_next.lui = 1'b1;
                dec_next.imm = {insn_word.i_form.imm12, insn_word.i_form.rs1,
                                insn_word.i_form.funct3, 12'd0};
            end
            OPC_LOAD: begin
                dec_next.kind     = OP_LOAD;
                dec_next.size     = size_of(insn_word.i_form.funct3);
                dec_next.sign_ext = ~insn_word.i_form.funct3[2];
            end
            OPC_STORE: begin
                dec_next.kind = OP_STORE;
                dec_next.rd   = 5'd0;
                dec_next.size = size_of(insn_word.s_form.funct3);
                dec_next.imm  = {{20{insn_word.s_form.imm_hi[6]}},
                                 insn_word.s_form.imm_hi, insn_word.s_form.imm_lo};
            end
            OPC_SYSTEM: begin
                dec_next.rd = 5'd0;
                // csrrw only
                if (insn_word.i_form.funct3 == 3'b001)
                    dec_next.kind = OP_CSR_WRITE;
            end
            default: begin
                // unsupported, becomes a no-op
                dec_next.rd = 5'd0;
            end
        endcase
    end

    // ------------------------------
    // one-slot stage
    // ------------------------------
    assign insn_ready = !slot_valid || dec_ready;
    assign dec_valid  = slot_valid;
    assign dec_op     = slot_op;

    always_ff @(posedge clock) begin
        if (reset)
            slot_valid <= 1'b0;
        else if (insn_valid && insn_ready)
            slot_valid <= 1'b1;
        else if (dec_ready)
            slot_valid <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (insn_valid && insn_ready)
            slot_op <= dec_next;
    end

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    output logic        fetch_valid,
    output logic [31:0] fetch_addr,
    input  logic        fetch_ready,
    input  logic [31:0] fetch_data,

    output logic        insn_valid,
    input  logic        insn_ready,
    output insn_u       insn_word
);

    logic [31:0] pc;
    logic        buf_valid;
    insn_u       buf_word;

    assign fetch_addr = pc;
    assign insn_valid = buf_valid;
    assign insn_word  = buf_word;

    // request goes out one cycle after the buffer is seen empty
    always_ff @(posedge clock) begin
        if (reset) begin
            pc          <= 32'd0;
            fetch_valid <= 1'b0;
            buf_valid   <= 1'b0;
        end else begin
            if (fetch_valid && fetch_ready) begin
                fetch_valid <= 1'b0;
                buf_valid   <= 1'b1;
                pc          <= pc + 32'd4;
            end else if (!fetch_valid && !buf_valid) begin
                fetch_valid <= 1'b1;
            end
            // never overlaps the fill, fetch only runs on an empty buffer
            if (insn_valid && insn_ready)
                buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_valid && fetch_ready)
            buf_word <= fetch_data;
    end

endmodule

// ==== verilog/bus_pkg.sv ====
package bus_pkg;
    import core_pkg::*;

    typedef struct packed {
        logic [31:0] addr;
        mem_size_e   size;
        logic        sign_ext;
    } mem_rd_req_t;

    // data is right-aligned, memory places the lanes
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        mem_size_e   size;
    } mem_wr_req_t;

    typedef struct packed {
        op_kind_e    kind;
        logic [4:0]  rd;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] alu;
        mem_size_e   size;
        logic        sign_ext;
        logic [11:0] csr_addr;
        logic [31:0] csr_data;
    } exec_op_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic [11:0] addr;
        logic [31:0] data;
    } csr_ev_t;

endpackage

// ==== verilog/core_pkg.sv ====
package core_pkg;

    // ------------------------------
    // opcodes
    // ------------------------------
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [1:0] {
        OP_ALU       = 2'd0,
        OP_LOAD      = 2'd1,
        OP_STORE     = 2'd2,
        OP_CSR_WRITE = 2'd3
    } op_kind_e;

    // same code as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // ------------------------------
    // instruction word views
    // ------------------------------
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } insn_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } insn_s_t;

    typedef union packed {
        insn_i_t i_form;
        insn_s_t s_form;
    } insn_u;

    typedef struct packed {
        op_kind_e    kind;
        mem_size_e   size;
        logic        sign_ext;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic [11:0] csr_addr;
        logic        lui;
    } decoded_op_t;

endpackage
